// File: sources.f
source/isaPkg.sv
source/pipePkg.sv
source/hazardIf.sv
source/instrDecoder.sv
source/condUnit.sv
source/ctrlPipeline.sv
source/hazardUnit.sv
source/armCtrlTop.sv
test/armCtrlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= armCtrlTb
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/armCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

module armCtrlTb;

  localparam int clkPeriod      = 8;
  localparam int resetCycles    = 5;
  localparam int directedCycles = 140;  // Upper bound of the directed part
  localparam int randomCycles   = 200;

  localparam logic [3:0]  alCond     = 4'he;
  localparam logic [1:0]  dpClass    = 2'b00;
  localparam logic [1:0]  memClass   = 2'b01;
  localparam logic [1:0]  brClass    = 2'b10;
  localparam logic [1:0]  undefClass = 2'b11;
  localparam logic [31:0] idleInstr  = {4'he, 2'b11, 26'd0};  // Decodes to a bubble

  logic          clk;
  logic          rstN;
  logic [31:0]   instrD;
  isaPkg::flagsT aluFlagsE;
  logic [2:0]    shiftOpD;
  logic          noRegWrite;
  logic          memStall;

  logic [1:0]    regSrcD;
  logic [1:0]    immSrcD;
  logic          aluSrcE;
  isaPkg::aluOpE aluControlE;
  logic          rSelectE;
  logic          rsrSelectE;
  logic [2:0]    shiftOpE;
  logic [1:0]    prevCvE;
  logic          branchTakenE;
  logic          memWriteM;
  logic          memtoRegW;
  logic          regWriteW;
  logic          pcSrcW;
  logic          stallF;
  logic          stallD;
  logic          flushD;

  logic [31:0] lcgState = 32'hf6c2;
  int          errorCount = 0;
  int          checkedCycles = 0;

  // Reference model state
  pipePkg::ctrlWordT dCtrl;
  pipePkg::ctrlWordT eCtrl;
  logic [3:0]        eCond;
  logic [2:0]        eShiftOp;
  logic [3:0]        eRd;
  logic [3:0]        mFlags;  // N Z C V
  logic              mMemWrite;
  logic              mMemtoReg;
  logic              mRegWrite;
  logic              mPcSrc;
  logic              wMemtoReg;
  logic              wRegWrite;
  logic              wPcSrc;
  logic              ePass;
  logic              expBranchTaken;
  logic              loadUse;
  logic              pcPending;
  logic              expFlushE;
  logic              expStallF;
  logic              expStallD;
  logic              expFlushD;

  armCtrlTop i_armCtrlTop (
    .clk          (clk),
    .rstN         (rstN),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .shiftOpD     (shiftOpD),
    .noRegWrite   (noRegWrite),
    .memStall     (memStall),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .rSelectE     (rSelectE),
    .rsrSelectE   (rsrSelectE),
    .shiftOpE     (shiftOpE),
    .prevCvE      (prevCvE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .memtoRegW    (memtoRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [31:0] makeInstr(input logic [3:0] cond, input logic [1:0] cls,
      input logic i, input logic [3:0] op, input logic s, input logic [3:0] rn,
      input logic [3:0] rd, input logic [11:0] low);
    return {cond, cls, i, op, s, rn, rd, low};
  endfunction

  // Even and odd codes form pairs, the odd one negates
  function automatic logic condPass(input logic [3:0] cond, input logic [3:0] nzcv);
    logic n, z, c, v, r;
    {n, z, c, v} = nzcv;
    case (cond[3:1])
      3'd0: r = z;
      3'd1: r = c;
      3'd2: r = n;
      3'd3: r = v;
      3'd4: r = c & ~z;         // HI
      3'd5: r = (n == v);       // GE
      3'd6: r = ~z & (n == v);  // GT
      default: r = 1'b1;        // AL
    endcase
    if (cond[0]) begin
      r = (cond[3:1] == 3'd7) ? 1'b0 : ~r;  // NV never passes
    end
    return r;
  endfunction

  function automatic pipePkg::ctrlWordT refDecode(input logic [31:0] instr,
      input logic [2:0] shOp);
    pipePkg::ctrlWordT cw;
    cw = '0;
    if (instr[27:26] == dpClass) begin
      cw.aluSrc     = instr[25];
      cw.regWrite   = 1'b1;
      cw.aluControl = isaPkg::aluOpE'(instr[24:21]);
      cw.flagWrite  = {2{instr[20]}};
      cw.rSelect    = ~instr[25] & ~shOp[0];
      cw.rsrSelect  = ~instr[25] & shOp[0];
    end else if (instr[27:26] == memClass) begin
      cw.immSrc     = 2'b01;
      cw.aluSrc     = 1'b1;
      cw.aluControl = isaPkg::opAdd;
      cw.memtoReg   = instr[20];
      cw.regWrite   = instr[20];
      cw.memWrite   = ~instr[20];
      cw.regSrc     = instr[20] ? 2'b00 : 2'b10;
    end else if (instr[27:26] == brClass) begin
      cw.regSrc     = 2'b01;
      cw.immSrc     = 2'b10;
      cw.aluSrc     = 1'b1;
      cw.branch     = 1'b1;
      cw.aluControl = isaPkg::opAdd;
    end
    cw.pcSrc = cw.branch | (cw.regWrite & (instr[15:12] == 4'hf));
    return cw;
  endfunction

  always_comb begin
    dCtrl          = refDecode(instrD, shiftOpD);
    ePass          = condPass(eCond, mFlags);
    expBranchTaken = eCtrl.branch & ePass;
    loadUse        = eCtrl.memtoReg & ~memStall & ((eRd == instrD[19:16]) |
                     ((instrD[27:26] == memClass) & ~instrD[20] & (eRd == instrD[15:12])));
    pcPending      = dCtrl.pcSrc | eCtrl.pcSrc | mPcSrc;
    expFlushE      = loadUse | (expBranchTaken & ~memStall);
    expStallF      = loadUse | memStall | pcPending;
    expStallD      = loadUse | memStall;
    expFlushD      = (pcPending | expBranchTaken) & ~memStall;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      eCtrl     <= '0;
      eCond     <= '0;
      eShiftOp  <= '0;
      eRd       <= '0;
      mFlags    <= '0;
      {mMemWrite, mMemtoReg, mRegWrite, mPcSrc} <= '0;
      {wMemtoReg, wRegWrite, wPcSrc} <= '0;
    end else begin
      if (expFlushE) begin
        eCtrl    <= '0;
        eCond    <= '0;
        eShiftOp <= '0;
        eRd      <= '0;
      end else if (!memStall) begin
        eCtrl    <= dCtrl;
        eCond    <= instrD[31:28];
        eShiftOp <= shiftOpD;
        eRd      <= instrD[15:12];
      end
      if (!memStall) begin
        mMemWrite <= eCtrl.memWrite & ePass;
        mMemtoReg <= eCtrl.memtoReg;
        mRegWrite <= eCtrl.regWrite & ePass & ~noRegWrite;
        mPcSrc    <= eCtrl.pcSrc & ePass;
        if (ePass && eCtrl.flagWrite[1]) mFlags[3:2] <= {aluFlagsE.n, aluFlagsE.z};
        if (ePass && eCtrl.flagWrite[0]) mFlags[1:0] <= {aluFlagsE.c, aluFlagsE.v};
      end
      if (memStall) begin
        {wMemtoReg, wRegWrite, wPcSrc} <= '0;  // Bubble into writeback
      end else begin
        {wMemtoReg, wRegWrite, wPcSrc} <= {mMemtoReg, mRegWrite, mPcSrc};
      end
    end
  end

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
      input logic [31:0] actVal);
    errorCount++;
    $display("FAIL %0t ns %s expected %0h actual %0h", $time, name, expVal, actVal);
  endtask

  always @(negedge clk) begin
    if (rstN) checkedCycles++;
  end

  // Outputs are sampled mid-cycle
  assert property (@(negedge clk) disable iff (!rstN) regSrcD == dCtrl.regSrc)
    else reportMismatch("regSrcD", 32'(dCtrl.regSrc), 32'(regSrcD));
  assert property (@(negedge clk) disable iff (!rstN) immSrcD == dCtrl.immSrc)
    else reportMismatch("immSrcD", 32'(dCtrl.immSrc), 32'(immSrcD));
  assert property (@(negedge clk) disable iff (!rstN) aluSrcE == eCtrl.aluSrc)
    else reportMismatch("aluSrcE", 32'(eCtrl.aluSrc), 32'(aluSrcE));
  assert property (@(negedge clk) disable iff (!rstN) aluControlE == eCtrl.aluControl)
    else reportMismatch("aluControlE", 32'(eCtrl.aluControl), 32'(aluControlE));
  assert property (@(negedge clk) disable iff (!rstN) rSelectE == eCtrl.rSelect)
    else reportMismatch("rSelectE", 32'(eCtrl.rSelect), 32'(rSelectE));
  assert property (@(negedge clk) disable iff (!rstN) rsrSelectE == eCtrl.rsrSelect)
    else reportMismatch("rsrSelectE", 32'(eCtrl.rsrSelect), 32'(rsrSelectE));
  assert property (@(negedge clk) disable iff (!rstN) shiftOpE == eShiftOp)
    else reportMismatch("shiftOpE", 32'(eShiftOp), 32'(shiftOpE));
  assert property (@(negedge clk) disable iff (!rstN) prevCvE == mFlags[1:0])
    else reportMismatch("prevCvE", 32'(mFlags[1:0]), 32'(prevCvE));
  assert property (@(negedge clk) disable iff (!rstN) branchTakenE == expBranchTaken)
    else reportMismatch("branchTakenE", 32'(expBranchTaken), 32'(branchTakenE));
  assert property (@(negedge clk) disable iff (!rstN) memWriteM == mMemWrite)
    else reportMismatch("memWriteM", 32'(mMemWrite), 32'(memWriteM));
  assert property (@(negedge clk) disable iff (!rstN) memtoRegW == wMemtoReg)
    else reportMismatch("memtoRegW", 32'(wMemtoReg), 32'(memtoRegW));
  assert property (@(negedge clk) disable iff (!rstN) regWriteW == wRegWrite)
    else reportMismatch("regWriteW", 32'(wRegWrite), 32'(regWriteW));
  assert property (@(negedge clk) disable iff (!rstN) pcSrcW == wPcSrc)
    else reportMismatch("pcSrcW", 32'(wPcSrc), 32'(pcSrcW));
  assert property (@(negedge clk) disable iff (!rstN) stallF == expStallF)
    else reportMismatch("stallF", 32'(expStallF), 32'(stallF));
  assert property (@(negedge clk) disable iff (!rstN) stallD == expStallD)
    else reportMismatch("stallD", 32'(expStallD), 32'(stallD));
  assert property (@(negedge clk) disable iff (!rstN) flushD == expFlushD)
    else reportMismatch("flushD", 32'(expFlushD), 32'(flushD));

  // One cycle of stimulus, flags and noRegWrite drawn fresh each time
  task automatic issue(input logic [31:0] instr, input logic [2:0] shOp, input logic stall);
    logic [31:0] rnd;
    rnd = nextRand();
    @(posedge clk);
    #1;
    instrD     = instr;
    shiftOpD   = shOp;
    memStall   = stall;
    aluFlagsE  = rnd[7:4];
    noRegWrite = (rnd[10:8] == 3'd0);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) issue(idleInstr, 3'b000, 1'b0);
  endtask

  initial begin
    #(clkPeriod * (resetCycles + directedCycles + randomCycles) + 500);
    $display("Timeout, stimulus did not finish within the expected time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [1:0]  cls;
    logic [3:0]  rd;
    rstN       = 1'b0;
    instrD     = idleInstr;
    aluFlagsE  = '0;
    shiftOpD   = 3'b000;
    noRegWrite = 1'b0;
    memStall   = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    idle(2);

    // One instruction of each class and form
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd1, 4'd2, 12'h005), 3'b000, 1'b0);
    issue(makeInstr(alCond, dpClass, 1'b0, 4'h2, 1'b0, 4'd1, 4'd2, 12'h003), 3'b010, 1'b0);
    issue(makeInstr(alCond, dpClass, 1'b0, 4'hc, 1'b0, 4'd1, 4'd2, 12'h213), 3'b101, 1'b0);
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b1, 4'd1, 4'd5, 12'h004), 3'b000, 1'b0);
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b0, 4'd1, 4'd6, 12'h008), 3'b000, 1'b0);
    issue(makeInstr(alCond, undefClass, 1'b0, 4'h0, 1'b0, 4'd0, 4'd0, 12'h000), 3'b000, 1'b0);
    issue(makeInstr(alCond, brClass, 1'b1, 4'h0, 1'b0, 4'd0, 4'd0, 12'h010), 3'b000, 1'b0);
    idle(4);

    // Load followed by a dependent add, held while decode stalls
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b1, 4'd1, 4'd3, 12'h000), 3'b000, 1'b0);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd3, 4'd4, 12'h001), 3'b000, 1'b0);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd3, 4'd4, 12'h001), 3'b000, 1'b0);
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b1, 4'd1, 4'd7, 12'h000), 3'b000, 1'b0);
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b0, 4'd2, 4'd7, 12'h000), 3'b000, 1'b0);
    idle(3);

    // PC written by a MOV, then a plain branch
    issue(makeInstr(alCond, dpClass, 1'b0, 4'hd, 1'b0, 4'd0, 4'hf, 12'h00e), 3'b000, 1'b0);
    idle(4);
    issue(makeInstr(alCond, brClass, 1'b1, 4'h0, 1'b0, 4'd0, 4'd0, 12'h020), 3'b000, 1'b0);
    idle(4);

    // Memory stall with a load and a flag-setting add in flight
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b1, 4'd1, 4'd2, 12'h001), 3'b000, 1'b0);
    issue(makeInstr(alCond, memClass, 1'b0, 4'hc, 1'b1, 4'd1, 4'd8, 12'h000), 3'b000, 1'b0);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd2, 4'd9, 12'h001), 3'b000, 1'b1);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd2, 4'd9, 12'h001), 3'b000, 1'b1);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd2, 4'd9, 12'h001), 3'b000, 1'b1);
    issue(makeInstr(alCond, dpClass, 1'b1, 4'h4, 1'b0, 4'd2, 4'd9, 12'h001), 3'b000, 1'b0);
    idle(4);

    // Compare with random flags, then a branch on each condition
    for (int c = 0; c < 15; c++) begin
      issue(makeInstr(alCond, dpClass, 1'b1, 4'ha, 1'b1, 4'd1, 4'd0, 12'h000), 3'b000, 1'b0);
      issue(makeInstr(4'(c), brClass, 1'b1, 4'h0, 1'b0, 4'd0, 4'd0, 12'h040), 3'b000, 1'b0);
      idle(2);
    end

    // Random mix of classes, conditions, registers and stalls
    for (int k = 0; k < randomCycles; k++) begin
      rnd  = nextRand();
      rnd2 = nextRand();
      cls  = rnd[2] ? dpClass : rnd[1:0];
      rd   = (rnd[8:6] == 3'd7) ? 4'hf : {1'b0, rnd[8:6]};
      issue(makeInstr(4'(rnd2 % 15), cls, rnd[9], rnd[13:10], rnd[14], {1'b0, rnd[5:3]}, rd,
                      rnd2[27:16]), rnd[17:15], rnd[20:18] == 3'd0);
    end
    idle(4);

    @(negedge clk);
    $display("%0d cycles checked, %0d mismatches", checkedCycles, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/armCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

module armCtrlTop (
  input  logic          clk,
  input  logic          rstN,
  input  logic [31:0]   instrD,
  input  isaPkg::flagsT aluFlagsE,
  input  logic [2:0]    shiftOpD,
  input  logic          noRegWrite,
  input  logic          memStall,
  output logic [1:0]    regSrcD,
  output logic [1:0]    immSrcD,
  output logic          aluSrcE,
  output isaPkg::aluOpE aluControlE,
  output logic          rSelectE,
  output logic          rsrSelectE,
  output logic [2:0]    shiftOpE,
  output logic [1:0]    prevCvE,
  output logic          branchTakenE,
  output logic          memWriteM,
  output logic          memtoRegW,
  output logic          regWriteW,
  output logic          pcSrcW,
  output logic          stallF,
  output logic          stallD,
  output logic          flushD
);

  hazardIf hz (.clk(clk));

  ctrlPipeline i_ctrlPipeline (
    .clk         (clk),
    .rstN        (rstN),
    .instrD      (instrD),
    .shiftOpD    (shiftOpD),
    .aluFlagsE   (aluFlagsE),
    .noRegWrite  (noRegWrite),
    .hz          (hz.pipe),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluSrcE     (aluSrcE),
    .aluControlE (aluControlE),
    .rSelectE    (rSelectE),
    .rsrSelectE  (rsrSelectE),
    .shiftOpE    (shiftOpE),
    .prevCvE     (prevCvE),
    .memWriteM   (memWriteM),
    .memtoRegW   (memtoRegW),
    .regWriteW   (regWriteW),
    .pcSrcW      (pcSrcW)
  );

  hazardUnit i_hazardUnit (
    .instrD   (instrD),
    .memStall (memStall),
    .hz       (hz.haz),
    .stallF   (stallF),
    .stallD   (stallD),
    .flushD   (flushD)
  );

  assign branchTakenE = hz.branchTakenE;

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  logic [31:0] instrD,
  input  logic        memStall,
  hazardIf.haz        hz,
  output logic        stallF,
  output logic        stallD,
  output logic        flushD
);

  isaPkg::instrClassE instrClassD;
  logic [3:0]         rnD;
  logic [3:0]         rdD;
  logic               isStoreD;
  logic               rnMatch;
  logic               rdMatch;
  logic               loadUse;

  assign instrClassD = isaPkg::instrClassE'(instrD[isaPkg::classMsb:isaPkg::classLsb]);
  assign rnD         = instrD[isaPkg::rnMsb:isaPkg::rnLsb];
  assign rdD         = instrD[isaPkg::rdMsb:isaPkg::rdLsb];
  assign isStoreD    = (instrClassD == isaPkg::memory) & ~instrD[isaPkg::lBit];

  // STR also reads Rd as store data
  assign rnMatch = (hz.rdE == rnD);
  assign rdMatch = isStoreD & (hz.rdE == rdD);

  // Masked while memStall freezes the whole pipe
  assign loadUse = hz.memtoRegE & (rnMatch | rdMatch) & ~memStall;

  assign stallF = loadUse | memStall | hz.pcWrPendingF;
  assign stallD = loadUse | memStall;
  assign flushD = (hz.pcWrPendingF | hz.branchTakenE) & ~memStall;

  assign hz.flushE = loadUse | (hz.branchTakenE & ~memStall);
  assign hz.stallE = memStall;
  assign hz.stallM = memStall;
  assign hz.flushW = memStall;

  // The bubble flushed into execute ends the stall
  assert property (@(posedge hz.clk)
    loadUse |=> !loadUse)
    else $error("hazardUnit: load-use stall longer than one cycle");

endmodule

`default_nettype wire

// File: source/ctrlPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module ctrlPipeline (
  input  logic          clk,
  input  logic          rstN,
  input  logic [31:0]   instrD,
  input  logic [2:0]    shiftOpD,
  input  isaPkg::flagsT aluFlagsE,
  input  logic          noRegWrite,
  hazardIf.pipe         hz,
  output logic [1:0]    regSrcD,
  output logic [1:0]    immSrcD,
  output logic          aluSrcE,
  output isaPkg::aluOpE aluControlE,
  output logic          rSelectE,
  output logic          rsrSelectE,
  output logic [2:0]    shiftOpE,
  output logic [1:0]    prevCvE,
  output logic          memWriteM,
  output logic          memtoRegW,
  output logic          regWriteW,
  output logic          pcSrcW
);

  pipePkg::ctrlWordT ctrlD;
  pipePkg::exStageT  exNext;
  pipePkg::exStageT  exStage;
  isaPkg::flagsT     flagsE;
  logic              condExE;
  logic              regWriteGatedE;
  logic              memWriteGatedE;
  logic              pcSrcGatedE;
  logic              memtoRegM;
  logic              regWriteM;
  logic              pcSrcM;

  instrDecoder i_instrDecoder (
    .instrD   (instrD),
    .shiftOpD (shiftOpD),
    .ctrlD    (ctrlD)
  );

  assign regSrcD = ctrlD.regSrc;
  assign immSrcD = ctrlD.immSrc;

  always_comb begin
    exNext.aluSrc     = ctrlD.aluSrc;
    exNext.memtoReg   = ctrlD.memtoReg;
    exNext.regWrite   = ctrlD.regWrite;
    exNext.memWrite   = ctrlD.memWrite;
    exNext.branch     = ctrlD.branch;
    exNext.pcSrc      = ctrlD.pcSrc;
    exNext.flagWrite  = ctrlD.flagWrite;
    exNext.aluControl = ctrlD.aluControl;
    exNext.rSelect    = ctrlD.rSelect;
    exNext.rsrSelect  = ctrlD.rsrSelect;
    exNext.cond       = isaPkg::condE'(instrD[isaPkg::condMsb:isaPkg::condLsb]);
    exNext.shiftOp    = shiftOpD;
    exNext.rd         = instrD[isaPkg::rdMsb:isaPkg::rdLsb];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exStage <= '0;
    end else if (hz.flushE) begin
      exStage <= '0;  // Flush beats stall
    end else if (!hz.stallE) begin
      exStage <= exNext;
    end
  end

  condUnit i_condUnit (
    .clk       (clk),
    .rstN      (rstN),
    .stallE    (hz.stallE),
    .cond      (exStage.cond),
    .aluFlags  (aluFlagsE),
    .flagWrite (exStage.flagWrite),
    .condEx    (condExE),
    .flags     (flagsE)
  );

  assign aluSrcE     = exStage.aluSrc;
  assign aluControlE = exStage.aluControl;
  assign rSelectE    = exStage.rSelect;
  assign rsrSelectE  = exStage.rsrSelect;
  assign shiftOpE    = exStage.shiftOp;
  assign prevCvE     = {flagsE.c, flagsE.v};  // Carry in for ADC, SBC, RSC

  assign regWriteGatedE  = exStage.regWrite & condExE & ~noRegWrite;
  assign memWriteGatedE  = exStage.memWrite & condExE;
  assign pcSrcGatedE     = exStage.pcSrc & condExE;
  assign hz.branchTakenE = exStage.branch & condExE;
  assign hz.memtoRegE    = exStage.memtoReg;
  assign hz.rdE          = exStage.rd;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <= '0;
    end else if (!hz.stallM) begin
      {memWriteM, memtoRegM, regWriteM, pcSrcM} <=
        {memWriteGatedE, exStage.memtoReg, regWriteGatedE, pcSrcGatedE};
    end
  end

  assign hz.regWriteM = regWriteM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      {memtoRegW, regWriteW, pcSrcW} <= '0;
    end else if (hz.flushW) begin
      {memtoRegW, regWriteW, pcSrcW} <= '0;  // Bubble during memory stall
    end else begin
      {memtoRegW, regWriteW, pcSrcW} <= {memtoRegM, regWriteM, pcSrcM};
    end
  end

  assign hz.pcWrPendingF = ctrlD.pcSrc | exStage.pcSrc | pcSrcM;

  // Writeback fills only while the memory stage moves
  assert property (@(posedge clk) disable iff (!rstN)
    $rose(regWriteW) |-> $past(regWriteM && !hz.stallM))
    else $error("ctrlPipeline: regWriteW rose without a moving regWriteM");

  assert property (@(posedge clk) disable iff (!rstN)
    $rose(pcSrcW) |-> $past(pcSrcM && !hz.stallM))
    else $error("ctrlPipeline: pcSrcW rose without a moving pcSrcM");

endmodule

`default_nettype wire

// File: source/condUnit.sv
`timescale 1ns/1ps
`default_nettype none

module condUnit (
  input  logic          clk,
  input  logic          rstN,
  input  logic          stallE,
  input  isaPkg::condE  cond,
  input  isaPkg::flagsT aluFlags,
  input  logic [1:0]    flagWrite,
  output logic          condEx,
  output isaPkg::flagsT flags
);

  logic ge;

  assign ge = (flags.n == flags.v);

  always_comb begin
    case (cond)
      isaPkg::condEq: condEx = flags.z;
      isaPkg::condNe: condEx = ~flags.z;
      isaPkg::condCs: condEx = flags.c;
      isaPkg::condCc: condEx = ~flags.c;
      isaPkg::condMi: condEx = flags.n;
      isaPkg::condPl: condEx = ~flags.n;
      isaPkg::condVs: condEx = flags.v;
      isaPkg::condVc: condEx = ~flags.v;
      isaPkg::condHi: condEx = flags.c & ~flags.z;
      isaPkg::condLs: condEx = ~flags.c | flags.z;
      isaPkg::condGe: condEx = ge;
      isaPkg::condLt: condEx = ~ge;
      isaPkg::condGt: condEx = ~flags.z & ge;
      isaPkg::condLe: condEx = flags.z | ~ge;
      isaPkg::condAl: condEx = 1'b1;
      default:        condEx = 1'b0;  // NV never executes
    endcase
  end

  // NZ and CV groups are written independently
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (!stallE) begin
      if (condEx && flagWrite[1]) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
      end
      if (condEx && flagWrite[0]) begin
        flags.c <= aluFlags.c;
        flags.v <= aluFlags.v;
      end
    end
  end

  // Decoder never hands NV to a moving execute stage
  assert property (@(posedge clk) disable iff (!rstN)
    !stallE |-> cond != isaPkg::condNv)
    else $error("condUnit: NV condition in execute");

endmodule

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic [31:0]       instrD,
  input  logic [2:0]        shiftOpD,
  output pipePkg::ctrlWordT ctrlD
);

  isaPkg::instrClassE instrClass;
  logic               immForm;
  logic               setFlags;
  logic               isLoad;
  logic [3:0]         rd;

  assign instrClass = isaPkg::instrClassE'(instrD[isaPkg::classMsb:isaPkg::classLsb]);
  assign immForm    = instrD[isaPkg::immBit];
  assign setFlags   = instrD[isaPkg::sBit];
  assign isLoad     = instrD[isaPkg::lBit];
  assign rd         = instrD[isaPkg::rdMsb:isaPkg::rdLsb];

  always_comb begin
    ctrlD = '0;  // Undefined class stays a bubble
    case (instrClass)
      isaPkg::dataProc: begin
        ctrlD.regSrc     = 2'b00;
        ctrlD.immSrc     = 2'b00;
        ctrlD.aluSrc     = immForm;
        ctrlD.regWrite   = 1'b1;  // Compares cleared later via noRegWrite
        ctrlD.aluControl = isaPkg::aluOpE'(instrD[isaPkg::opMsb:isaPkg::opLsb]);
        ctrlD.flagWrite  = {2{setFlags}};
        ctrlD.rSelect    = ~immForm & ~shiftOpD[0];  // shiftOpD[0] is instr bit 4
        ctrlD.rsrSelect  = ~immForm & shiftOpD[0];
      end
      isaPkg::memory: begin
        ctrlD.immSrc     = 2'b01;
        ctrlD.aluSrc     = 1'b1;
        ctrlD.aluControl = isaPkg::opAdd;  // Base plus offset
        if (isLoad) begin
          ctrlD.regSrc   = 2'b00;
          ctrlD.memtoReg = 1'b1;
          ctrlD.regWrite = 1'b1;
        end else begin
          ctrlD.regSrc   = 2'b10;  // Rd read as store data
          ctrlD.memWrite = 1'b1;
        end
      end
      isaPkg::branch: begin
        ctrlD.regSrc     = 2'b01;  // PC as first operand
        ctrlD.immSrc     = 2'b10;
        ctrlD.aluSrc     = 1'b1;
        ctrlD.branch     = 1'b1;
        ctrlD.aluControl = isaPkg::opAdd;
      end
      default: begin
        ctrlD = '0;
      end
    endcase

    // Any write to R15 redirects fetch
    ctrlD.pcSrc = ctrlD.branch | (ctrlD.regWrite & (rd == isaPkg::pcReg));
  end

endmodule

`default_nettype wire

// File: source/hazardIf.sv
`timescale 1ns/1ps
`default_nettype none

interface hazardIf (
  input logic clk
);

  logic       regWriteM;
  logic       memtoRegE;     // Load in execute
  logic [3:0] rdE;
  logic       pcWrPendingF;
  logic       branchTakenE;

  logic       stallE;
  logic       stallM;
  logic       flushE;
  logic       flushW;

  modport pipe (
    output regWriteM, memtoRegE, rdE, pcWrPendingF, branchTakenE,
    input  stallE, stallM, flushE, flushW
  );

  modport haz (
    input  clk,
    input  regWriteM, memtoRegE, rdE, pcWrPendingF, branchTakenE,
    output stallE, stallM, flushE, flushW
  );

endinterface

`default_nettype wire

// File: source/pipePkg.sv
`default_nettype none

package pipePkg;

  // Decoded controls of one instruction
  typedef struct packed {
    logic [1:0]    regSrc;
    logic [1:0]    immSrc;
    logic          aluSrc;
    logic          memtoReg;
    logic          regWrite;
    logic          memWrite;
    logic          branch;
    logic          pcSrc;
    logic [1:0]    flagWrite;   // NZ, CV
    isaPkg::aluOpE aluControl;
    logic          rSelect;     // Register, immediate shift
    logic          rsrSelect;   // Register, register shift
  } ctrlWordT;

  // Execute-stage register, decode-only fields dropped
  typedef struct packed {
    logic          aluSrc;
    logic          memtoReg;
    logic          regWrite;
    logic          memWrite;
    logic          branch;
    logic          pcSrc;
    logic [1:0]    flagWrite;
    isaPkg::aluOpE aluControl;
    logic          rSelect;
    logic          rsrSelect;
    isaPkg::condE  cond;
    logic [2:0]    shiftOp;
    logic [3:0]    rd;
  } exStageT;

endpackage

`default_nettype wire

// File: source/isaPkg.sv
`default_nettype none

package isaPkg;

  // Instruction class, bits 27:26
  typedef enum logic [1:0] {
    dataProc    = 2'b00,
    memory      = 2'b01,
    branch      = 2'b10,
    undefinedOp = 2'b11
  } instrClassE;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condE;

  // Data-processing opcodes, bits 24:21
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb,
    opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn,
    opOrr, opMov, opBic, opMvn
  } aluOpE;

  localparam logic [3:0] pcReg = 4'd15;  // R15 is the PC

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  localparam int condMsb  = 31;
  localparam int condLsb  = 28;
  localparam int classMsb = 27;
  localparam int classLsb = 26;
  localparam int immBit   = 25;  // I bit of data processing
  localparam int opMsb    = 24;
  localparam int opLsb    = 21;
  localparam int sBit     = 20;  // Set flags
  localparam int lBit     = 20;  // Load, 0 means store
  localparam int rnMsb    = 19;
  localparam int rnLsb    = 16;
  localparam int rdMsb    = 15;
  localparam int rdLsb    = 12;

endpackage

`default_nettype wire
